/* iq_pkg.sv */
`default_nettype none

package iq_pkg;

    localparam int preg_w = 6;
    localparam int rob_w  = 6;
    localparam int xlen   = 32;

    // bit 3 set marks the immediate forms.
    typedef enum logic [3:0] {
        op_add  = 4'h0,
        op_sub  = 4'h1,
        op_and  = 4'h2,
        op_or   = 4'h3,
        op_xor  = 4'h4,
        op_sll  = 4'h5,
        op_srl  = 4'h6,
        op_slt  = 4'h7,
        op_addi = 4'h8,
        op_andi = 4'h9,
        op_ori  = 4'ha,
        op_xori = 4'hb,
        op_slti = 4'hc,
        op_lui  = 4'hd
    } alu_op_e;

    typedef struct packed {
        logic [3:0]        opcode;
        logic [preg_w-1:0] rd;
        logic [preg_w-1:0] rs1;
        logic [preg_w-1:0] rs2;
        logic [9:0]        unused;
    } r_fmt_s;

    typedef struct packed {
        logic [3:0]        opcode;
        logic [preg_w-1:0] rd;
        logic [preg_w-1:0] rs1;
        logic [15:0]       imm;
    } i_fmt_s;

    typedef union packed {
        r_fmt_s r_fmt;
        i_fmt_s i_fmt;
    } instr_word_u;

    typedef struct packed {
        instr_word_u      word;
        logic [rob_w-1:0] rob;
    } disp_req_s;

    typedef struct packed {
        logic [rob_w-1:0]  rob;
        alu_op_e           op;
        logic [preg_w-1:0] rd;
        logic [preg_w-1:0] rs1;
        logic [preg_w-1:0] rs2;
        logic              use_imm;
        logic [xlen-1:0]   imm;
        logic              use_rs2;
    } uop_s;

    typedef struct packed {
        uop_s            uop;
        logic [xlen-1:0] src1;
        logic [xlen-1:0] src2;
    } issue_s;

    typedef struct packed {
        logic [rob_w-1:0]  rob;
        logic [preg_w-1:0] rd;
        logic [xlen-1:0]   value;
    } result_s;

    typedef struct packed {
        logic [preg_w-1:0] rd;
    } wakeup_s;

    // true when a is older than b; the top bit flips on each lap.
    function automatic logic rob_older(input logic [rob_w-1:0] a, input logic [rob_w-1:0] b);
        if (a[rob_w-1] == b[rob_w-1]) begin
            return a[rob_w-2:0] < b[rob_w-2:0];
        end
        return a[rob_w-2:0] > b[rob_w-2:0];
    endfunction

endpackage

`default_nettype wire

/* uop_decoder.sv */
`default_nettype none

module uop_decoder (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              disp_en,
    input  iq_pkg::disp_req_s disp_req,
    output logic              uop_en,
    output iq_pkg::uop_s      uop
);
    import iq_pkg::*;

    instr_word_u w;
    alu_op_e     op;
    uop_s        uop_d;

    assign w  = disp_req.word;
    assign op = alu_op_e'(w.r_fmt.opcode);

    always_comb begin
        uop_d     = '0;
        uop_d.rob = disp_req.rob;
        uop_d.op  = op;
        uop_d.rd  = w.r_fmt.rd;
        uop_d.rs1 = w.r_fmt.rs1;
        if (w.i_fmt.opcode[3]) begin
            // lui has no register source.
            if (op == op_lui) uop_d.rs1 = '0;
            uop_d.use_imm = 1'b1;
            case (op)
                op_addi, op_slti: uop_d.imm = {{16{w.i_fmt.imm[15]}}, w.i_fmt.imm};
                op_lui:           uop_d.imm = {w.i_fmt.imm, 16'h0000};
                default:          uop_d.imm = {16'h0000, w.i_fmt.imm};
            endcase
        end else begin
            uop_d.rs2     = w.r_fmt.rs2;
            uop_d.use_rs2 = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            uop_en <= 1'b0;
        end else begin
            uop_en <= disp_en;
        end
    end

    always_ff @(posedge clk) begin
        uop <= uop_d;
    end

endmodule

`default_nettype wire

/* issue_bank.sv */
`default_nettype none

module issue_bank #(
    parameter int bank_num  = 2,
    parameter int bank_size = 4
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            ins_en,
    input  iq_pkg::uop_s                    ins_uop,
    input  logic                            ins_rdy1,
    input  logic                            ins_rdy2,
    input  logic [bank_num-1:0]             wakeup_en,
    input  iq_pkg::wakeup_s                 wakeup [bank_num],
    input  logic                            redirect_en,
    input  logic [iq_pkg::rob_w-1:0]        redirect_rob,
    output logic                            sel_en,
    output iq_pkg::uop_s                    sel_uop,
    output logic [$clog2(bank_size+1)-1:0]  count,
    output logic                            full
);
    import iq_pkg::*;

    localparam int idx_w = (bank_size > 1) ? $clog2(bank_size) : 1;

    uop_s                 ent [bank_size];
    logic [bank_size-1:0] valid;
    logic [bank_size-1:0] rdy1;
    logic [bank_size-1:0] rdy2;
    logic [bank_size-1:0] wake1;
    logic [bank_size-1:0] wake2;
    logic [bank_size-1:0] flush;
    logic [idx_w-1:0]     free_idx;
    logic [idx_w-1:0]     sel_idx;

    // source match against every writeback lane.
    always_comb begin
        wake1 = '0;
        wake2 = '0;
        for (int i = 0; i < bank_size; i++) begin
            for (int l = 0; l < bank_num; l++) begin
                if (wakeup_en[l] && wakeup[l].rd == ent[i].rs1) wake1[i] = 1'b1;
                if (wakeup_en[l] && wakeup[l].rd == ent[i].rs2) wake2[i] = 1'b1;
            end
            flush[i] = redirect_en && valid[i] && rob_older(redirect_rob, ent[i].rob);
        end
    end

    // lowest free slot.
    always_comb begin
        free_idx = '0;
        for (int i = bank_size - 1; i >= 0; i--) begin
            if (!valid[i]) free_idx = idx_w'(i);
        end
    end

    // oldest entry with both sources ready.
    always_comb begin
        sel_en  = 1'b0;
        sel_idx = '0;
        for (int i = 0; i < bank_size; i++) begin
            if (valid[i] && rdy1[i] && rdy2[i] &&
                (!sel_en || rob_older(ent[i].rob, ent[sel_idx].rob))) begin
                sel_en  = 1'b1;
                sel_idx = idx_w'(i);
            end
        end
    end

    assign sel_uop = ent[sel_idx];
    assign full    = &valid;

    always_comb begin
        count = '0;
        for (int i = 0; i < bank_size; i++) begin
            count = count + valid[i];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
            rdy1  <= '0;
            rdy2  <= '0;
        end else begin
            for (int i = 0; i < bank_size; i++) begin
                rdy1[i] <= rdy1[i] | wake1[i];
                rdy2[i] <= rdy2[i] | wake2[i];
                if ((sel_en && sel_idx == idx_w'(i)) || flush[i]) valid[i] <= 1'b0;
                if (ins_en && !full && free_idx == idx_w'(i)) begin
                    valid[i] <= 1'b1;
                    rdy1[i]  <= ins_rdy1;
                    rdy2[i]  <= ins_rdy2;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ins_en && !full) ent[free_idx] <= ins_uop;
    end

endmodule

`default_nettype wire

/* int_issue_queue.sv */
`default_nettype none

module int_issue_queue #(
    parameter int bank_num  = 2,
    parameter int bank_size = 4
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      uop_en,
    input  iq_pkg::uop_s              uop,
    input  logic [bank_num-1:0]       wakeup_en,
    input  iq_pkg::wakeup_s           wakeup [bank_num],
    input  logic                      redirect_en,
    input  logic [iq_pkg::rob_w-1:0]  redirect_rob,
    output logic [iq_pkg::preg_w-1:0] rd_addr [2*bank_num],
    input  logic [iq_pkg::xlen-1:0]   rd_data [2*bank_num],
    output logic [iq_pkg::preg_w-1:0] rdy_addr [2],
    input  logic [1:0]                rdy_bits,
    output logic                      clr_en,
    output logic [iq_pkg::preg_w-1:0] clr_addr,
    output logic [bank_num-1:0]       iss_en,
    output iq_pkg::issue_s            iss [bank_num],
    output logic                      queue_full
);
    import iq_pkg::*;

    localparam int tgt_w = (bank_num > 1) ? $clog2(bank_num) : 1;
    localparam int cnt_w = $clog2(bank_size + 1);

    logic [cnt_w-1:0]    count [bank_num];
    logic [bank_num-1:0] full;
    logic [bank_num-1:0] sel_en;
    uop_s                sel_uop [bank_num];
    logic [tgt_w-1:0]    tgt;
    logic                accept;
    logic                wake1;
    logic                wake2;

    assign queue_full  = |full;
    assign accept      = uop_en && !queue_full &&
                         !(redirect_en && rob_older(redirect_rob, uop.rob));
    assign rdy_addr[0] = uop.rs1;
    assign rdy_addr[1] = uop.rs2;
    assign clr_en      = accept;
    assign clr_addr    = uop.rd;

    // fewest entries wins, ties to the lower bank.
    always_comb begin
        tgt = '0;
        for (int b = 1; b < bank_num; b++) begin
            if (count[b] < count[tgt]) tgt = tgt_w'(b);
        end
    end

    // a write completing this cycle is not yet in the ready table.
    always_comb begin
        wake1 = 1'b0;
        wake2 = 1'b0;
        for (int l = 0; l < bank_num; l++) begin
            if (wakeup_en[l] && wakeup[l].rd == uop.rs1) wake1 = 1'b1;
            if (wakeup_en[l] && wakeup[l].rd == uop.rs2) wake2 = 1'b1;
        end
    end

    for (genvar b = 0; b < bank_num; b++) begin : g_bank
        issue_bank #(
            .bank_num  (bank_num),
            .bank_size (bank_size)
        ) bank_i (
            .clk          (clk),
            .arst_n       (arst_n),
            .ins_en       (accept && tgt == tgt_w'(b)),
            .ins_uop      (uop),
            .ins_rdy1     (rdy_bits[0] | wake1),
            .ins_rdy2     (!uop.use_rs2 | rdy_bits[1] | wake2),
            .wakeup_en    (wakeup_en),
            .wakeup       (wakeup),
            .redirect_en  (redirect_en),
            .redirect_rob (redirect_rob),
            .sel_en       (sel_en[b]),
            .sel_uop      (sel_uop[b]),
            .count        (count[b]),
            .full         (full[b])
        );

        assign rd_addr[2*b]   = sel_uop[b].rs1;
        assign rd_addr[2*b+1] = sel_uop[b].rs2;

        always_ff @(posedge clk) begin
            iss[b].uop  <= sel_uop[b];
            iss[b].src1 <= rd_data[2*b];
            iss[b].src2 <= sel_uop[b].use_imm ? sel_uop[b].imm : rd_data[2*b+1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            iss_en <= '0;
        end else begin
            for (int b = 0; b < bank_num; b++) begin
                iss_en[b] <= sel_en[b] &&
                             !(redirect_en && rob_older(redirect_rob, sel_uop[b].rob));
            end
        end
    end

endmodule

`default_nettype wire

/* preg_file.sv */
`default_nettype none

module preg_file #(
    parameter int bank_num = 2
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [iq_pkg::preg_w-1:0] rd_addr [2*bank_num],
    output logic [iq_pkg::xlen-1:0]   rd_data [2*bank_num],
    input  logic [iq_pkg::preg_w-1:0] rdy_addr [2],
    output logic [1:0]                rdy_bits,
    input  logic                      clr_en,
    input  logic [iq_pkg::preg_w-1:0] clr_addr,
    input  logic [bank_num-1:0]       we,
    input  iq_pkg::result_s           wr [bank_num]
);
    import iq_pkg::*;

    localparam int preg_num = 1 << preg_w;

    logic [xlen-1:0]     regs [preg_num];
    logic [preg_num-1:0] ready;

    always_comb begin
        for (int i = 0; i < 2 * bank_num; i++) begin
            rd_data[i] = (rd_addr[i] == '0) ? '0 : regs[rd_addr[i]];
        end
        rdy_bits[0] = ready[rdy_addr[0]];
        rdy_bits[1] = ready[rdy_addr[1]];
    end

    // register 0 is never written or cleared.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < preg_num; r++) begin
                regs[r] <= '0;
            end
            ready <= '1;
        end else begin
            for (int l = 0; l < bank_num; l++) begin
                if (we[l] && wr[l].rd != '0) begin
                    regs[wr[l].rd]  <= wr[l].value;
                    ready[wr[l].rd] <= 1'b1;
                end
            end
            // a newer writer takes over the tag.
            if (clr_en && clr_addr != '0) ready[clr_addr] <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* int_alu.sv */
`default_nettype none

module int_alu #(
    parameter int bank_num = 2
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [bank_num-1:0]      iss_en,
    input  iq_pkg::issue_s           iss [bank_num],
    input  logic                     redirect_en,
    input  logic [iq_pkg::rob_w-1:0] redirect_rob,
    output logic [bank_num-1:0]      alu_en,
    output iq_pkg::result_s          alu_res [bank_num]
);
    import iq_pkg::*;

    function automatic logic [xlen-1:0] alu_calc(input alu_op_e op, input logic [xlen-1:0] a,
                                                 input logic [xlen-1:0] b);
        case (op)
            op_add, op_addi: return a + b;
            op_sub:          return a - b;
            op_and, op_andi: return a & b;
            op_or, op_ori:   return a | b;
            op_xor, op_xori: return a ^ b;
            op_sll:          return a << b[4:0];
            op_srl:          return a >> b[4:0];
            op_slt, op_slti: return {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            op_lui:          return b;
            default:         return '0;
        endcase
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alu_en <= '0;
        end else begin
            for (int l = 0; l < bank_num; l++) begin
                alu_en[l] <= iss_en[l] &&
                             !(redirect_en && rob_older(redirect_rob, iss[l].uop.rob));
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < bank_num; l++) begin
            alu_res[l].rob   <= iss[l].uop.rob;
            alu_res[l].rd    <= iss[l].uop.rd;
            alu_res[l].value <= alu_calc(iss[l].uop.op, iss[l].src1, iss[l].src2);
        end
    end

endmodule

`default_nettype wire

/* writeback_stage.sv */
`default_nettype none

module writeback_stage #(
    parameter int bank_num = 2
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [bank_num-1:0]      alu_en,
    input  iq_pkg::result_s          alu_res [bank_num],
    input  logic                     redirect_en,
    input  logic [iq_pkg::rob_w-1:0] redirect_rob,
    output logic [bank_num-1:0]      result_en,
    output iq_pkg::result_s          result [bank_num],
    output logic [bank_num-1:0]      wakeup_en,
    output iq_pkg::wakeup_s          wakeup [bank_num]
);
    import iq_pkg::*;

    logic [bank_num-1:0] wb_en;
    logic [bank_num-1:0] kill;
    result_s             wb_res [bank_num];

    // a younger result is suppressed in the redirect cycle itself.
    always_comb begin
        for (int l = 0; l < bank_num; l++) begin
            kill[l]      = redirect_en && rob_older(redirect_rob, wb_res[l].rob);
            result[l]    = wb_res[l];
            wakeup[l].rd = wb_res[l].rd;
        end
    end

    assign result_en = wb_en & ~kill;
    assign wakeup_en = result_en;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_en <= '0;
        end else begin
            for (int l = 0; l < bank_num; l++) begin
                wb_en[l] <= alu_en[l] && !(redirect_en && rob_older(redirect_rob, alu_res[l].rob));
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_res <= alu_res;
    end

endmodule

`default_nettype wire

/* int_backend_top.sv */
`default_nettype none

module int_backend_top #(
    parameter int bank_num  = 2,
    parameter int bank_size = 4
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     disp_en,
    input  iq_pkg::disp_req_s        disp_req,
    input  logic                     redirect_en,
    input  logic [iq_pkg::rob_w-1:0] redirect_rob,
    output logic                     queue_full,
    output logic [bank_num-1:0]      result_en,
    output iq_pkg::result_s          result [bank_num]
);
    import iq_pkg::*;

    logic                uop_en;
    uop_s                uop;
    logic [preg_w-1:0]   rd_addr [2*bank_num];
    logic [xlen-1:0]     rd_data [2*bank_num];
    logic [preg_w-1:0]   rdy_addr [2];
    logic [1:0]          rdy_bits;
    logic                clr_en;
    logic [preg_w-1:0]   clr_addr;
    logic [bank_num-1:0] iss_en;
    issue_s              iss [bank_num];
    logic [bank_num-1:0] alu_en;
    result_s             alu_res [bank_num];
    logic [bank_num-1:0] wakeup_en;
    wakeup_s             wakeup [bank_num];

    uop_decoder decode_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .disp_en  (disp_en),
        .disp_req (disp_req),
        .uop_en   (uop_en),
        .uop      (uop)
    );

    int_issue_queue #(
        .bank_num  (bank_num),
        .bank_size (bank_size)
    ) queue_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .uop_en       (uop_en),
        .uop          (uop),
        .wakeup_en    (wakeup_en),
        .wakeup       (wakeup),
        .redirect_en  (redirect_en),
        .redirect_rob (redirect_rob),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .rdy_addr     (rdy_addr),
        .rdy_bits     (rdy_bits),
        .clr_en       (clr_en),
        .clr_addr     (clr_addr),
        .iss_en       (iss_en),
        .iss          (iss),
        .queue_full   (queue_full)
    );

    preg_file #(
        .bank_num (bank_num)
    ) prf_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .rdy_addr (rdy_addr),
        .rdy_bits (rdy_bits),
        .clr_en   (clr_en),
        .clr_addr (clr_addr),
        .we       (result_en),
        .wr       (result)
    );

    int_alu #(
        .bank_num (bank_num)
    ) execute_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .iss_en       (iss_en),
        .iss          (iss),
        .redirect_en  (redirect_en),
        .redirect_rob (redirect_rob),
        .alu_en       (alu_en),
        .alu_res      (alu_res)
    );

    writeback_stage #(
        .bank_num (bank_num)
    ) result_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .alu_en       (alu_en),
        .alu_res      (alu_res),
        .redirect_en  (redirect_en),
        .redirect_rob (redirect_rob),
        .result_en    (result_en),
        .result       (result),
        .wakeup_en    (wakeup_en),
        .wakeup       (wakeup)
    );

endmodule

`default_nettype wire

/* tb_stim_table.svh */
`ifndef TB_STIM_TABLE_SVH
`define TB_STIM_TABLE_SVH

typedef struct packed {
    logic [3:0]  op;
    logic [5:0]  rd;
    logic [5:0]  rs1;
    logic [5:0]  rs2;
    logic [15:0] imm;
    logic        rnd;
    logic [5:0]  rob;
    logic        redir;
    logic        sync;
    logic        flushed;
    result_s     exp;
} row_s;

localparam int max_rows = 40;

row_s       rows [max_rows];
string      row_name [max_rows];
int         n_rows = 0;
logic [5:0] next_rob = '0;

// sync waits until every earlier op has written back.
function automatic void add_row(string name, logic [3:0] op, int rd, int rs1, int rs2,
                                logic [15:0] imm, bit rnd = 0, bit sync = 0);
    rows[n_rows]      = '0;
    rows[n_rows].op   = op;
    rows[n_rows].rd   = 6'(rd);
    rows[n_rows].rs1  = 6'(rs1);
    rows[n_rows].rs2  = 6'(rs2);
    rows[n_rows].imm  = imm;
    rows[n_rows].rnd  = rnd;
    rows[n_rows].sync = sync;
    rows[n_rows].rob  = next_rob;
    row_name[n_rows]  = name;
    next_rob          = next_rob + 6'd1;
    n_rows++;
endfunction

// redirect to the tag of the row given by back.
function automatic void add_redirect(string name, int back);
    rows[n_rows]       = '0;
    rows[n_rows].redir = 1'b1;
    rows[n_rows].rob   = rows[n_rows-back].rob;
    row_name[n_rows]   = name;
    n_rows++;
endfunction

function automatic void fill_table();
    add_row("load_r1_addi", op_addi, 1, 0, 0, 16'h0, 1, 1);
    add_row("load_r2_addi", op_addi, 2, 0, 0, 16'h0, 1);
    add_row("load_r3_lui", op_lui, 3, 0, 0, 16'h0, 1);
    add_row("load_r4_addi", op_addi, 4, 0, 0, 16'h0005);
    add_row("load_r5_lui", op_lui, 5, 0, 0, 16'h8000);
    add_row("r_add", op_add, 6, 1, 2, 16'h0);
    add_row("r_sub", op_sub, 7, 1, 2, 16'h0);
    add_row("r_and", op_and, 8, 1, 3, 16'h0);
    add_row("r_or", op_or, 9, 2, 3, 16'h0);
    add_row("r_xor", op_xor, 10, 1, 3, 16'h0);
    add_row("r_sll", op_sll, 11, 1, 4, 16'h0);
    add_row("r_srl", op_srl, 12, 5, 4, 16'h0);
    add_row("r_slt", op_slt, 13, 5, 1, 16'h0);
    add_row("i_addi_neg", op_addi, 14, 1, 0, 16'hfff0);
    add_row("i_slti_neg", op_slti, 15, 1, 0, 16'h8000);
    add_row("i_andi", op_andi, 16, 3, 0, 16'hff0f);
    add_row("i_ori", op_ori, 17, 2, 0, 16'h8001);
    add_row("i_xori", op_xori, 18, 1, 0, 16'hf00f);
    add_row("i_lui", op_lui, 19, 0, 0, 16'habcd);
    add_row("chain0", op_addi, 20, 19, 0, 16'h0001, 0, 1);
    add_row("chain1", op_sub, 21, 20, 2, 16'h0);
    add_row("chain2", op_xori, 22, 21, 0, 16'h00ff);
    add_row("chain3", op_add, 23, 22, 1, 16'h0);
    add_row("chain4", op_sll, 24, 23, 4, 16'h0);
    add_row("chain5", op_ori, 25, 24, 0, 16'h1234);
    add_row("chain6", op_srl, 26, 25, 4, 16'h0);
    add_row("chain7", op_addi, 27, 26, 0, 16'hfffe);
    add_row("redir_keep", op_addi, 28, 27, 0, 16'h0007, 0, 1);
    add_row("redir_kill_a", op_addi, 40, 1, 0, 16'h0001);
    add_row("redir_kill_b", op_addi, 41, 2, 0, 16'h0002);
    add_redirect("redirect", 3);
    add_row("after_redir", op_add, 29, 28, 1, 16'h0);
endfunction

task automatic check_result(input string name, input result_s exp, input result_s act);
    string exp_s;
    string act_s;
    checks++;
    if (exp !== act) begin
        errors++;
        exp_s = $sformatf("rob=%0d rd=%0d value=%08h", exp.rob, exp.rd, exp.value);
        act_s = $sformatf("rob=%0d rd=%0d value=%08h", act.rob, act.rd, act.value);
        $display("CHECK FAILED %s expected %s actual %s", name, exp_s, act_s);
    end else begin
        $display("%s: ok, value %08h", name, act.value);
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
        errors++;
        $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
    end else begin
        $display("%s: ok", name);
    end
endtask

`endif

/* tb_int_backend.sv */
`default_nettype none

module tb_int_backend;
    timeunit 1ns;
    timeprecision 100ps;
    import iq_pkg::*;

    localparam int bank_num  = 2;
    localparam int bank_size = 4;

    logic                clk;
    logic                arst_n;
    logic                disp_en;
    disp_req_s           disp_req;
    logic                redirect_en;
    logic [rob_w-1:0]    redirect_rob;
    logic                queue_full;
    logic [bank_num-1:0] result_en;
    result_s             result [bank_num];

    int          errors = 0;
    int          checks = 0;
    int          seed = 32'h62fc;
    int          seen_cnt = 0;
    int          sent_cnt = 0;
    int          total_exp = 0;
    int          row_of_rob [64];
    bit          seen [64];
    bit          table_ready = 0;
    logic [31:0] mregs [64];

    `include "tb_stim_table.svh"

    int_backend_top #(
        .bank_num  (bank_num),
        .bank_size (bank_size)
    ) dut_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .disp_en      (disp_en),
        .disp_req     (disp_req),
        .redirect_en  (redirect_en),
        .redirect_rob (redirect_rob),
        .queue_full   (queue_full),
        .result_en    (result_en),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reference alu semantics.
    function automatic logic [31:0] model_alu(logic [3:0] op, logic [31:0] a, logic [31:0] b);
        case (op)
            op_add, op_addi: return a + b;
            op_sub:          return a - b;
            op_and, op_andi: return a & b;
            op_or, op_ori:   return a | b;
            op_xor, op_xori: return a ^ b;
            op_sll:          return a << b[4:0];
            op_srl:          return a >> b[4:0];
            op_slt, op_slti: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:         return b;
        endcase
    endfunction

    function automatic logic [31:0] ext_imm(logic [3:0] op, logic [15:0] imm);
        if (op == op_lui) return {imm, 16'h0000};
        if (op == op_addi || op == op_slti) return {{16{imm[15]}}, imm};
        return {16'h0000, imm};
    endfunction

    function automatic logic [31:0] make_word(row_s r);
        if (r.op[3]) return {r.op, r.rd, r.rs1, r.imm};
        return {r.op, r.rd, r.rs1, r.rs2, 10'b0};
    endfunction

    // ops dispatched before a redirect with a younger tag never complete.
    task automatic build_model();
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < 64; i++) begin
            row_of_rob[i] = -1;
            mregs[i]      = '0;
        end
        for (int i = 0; i < n_rows; i++) begin
            if (rows[i].redir) begin
                for (int j = 0; j < i; j++) begin
                    if (!rows[j].redir && rows[j].rob > rows[i].rob) rows[j].flushed = 1'b1;
                end
            end
        end
        for (int i = 0; i < n_rows; i++) begin
            if (!rows[i].redir) begin
                if (rows[i].rnd) rows[i].imm = 16'($random(seed));
                a = (rows[i].op == op_lui) ? 32'h0 : mregs[rows[i].rs1];
                b = rows[i].op[3] ? ext_imm(rows[i].op, rows[i].imm) : mregs[rows[i].rs2];
                row_of_rob[rows[i].rob] = i;
                if (!rows[i].flushed) begin
                    rows[i].exp = {rows[i].rob, rows[i].rd, model_alu(rows[i].op, a, b)};
                    if (rows[i].rd != 0) mregs[rows[i].rd] = rows[i].exp.value;
                    total_exp++;
                end
            end
        end
    endtask

    initial begin
        disp_en      = 1'b0;
        disp_req     = '0;
        redirect_en  = 1'b0;
        redirect_rob = '0;
        arst_n       = 1'b0;
        fill_table();
        build_model();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        check_flag("reset_queue_full", 1'b0, queue_full);
        for (int l = 0; l < bank_num; l++) begin
            check_flag($sformatf("reset_result_en%0d", l), 1'b0, result_en[l]);
        end
        for (int i = 0; i < n_rows; i++) begin
            @(posedge clk);
            disp_en     <= 1'b0;
            redirect_en <= 1'b0;
            while ((rows[i].sync && sent_cnt != seen_cnt) || queue_full) @(posedge clk);
            if (rows[i].redir) begin
                redirect_en  <= 1'b1;
                redirect_rob <= rows[i].rob;
            end else begin
                disp_en       <= 1'b1;
                disp_req.word <= make_word(rows[i]);
                disp_req.rob  <= rows[i].rob;
                if (!rows[i].flushed) sent_cnt++;
            end
        end
        @(posedge clk);
        disp_en     <= 1'b0;
        redirect_en <= 1'b0;
        while (seen_cnt < total_exp) @(posedge clk);
        // give a stray younger result time to show up.
        repeat (20) @(posedge clk);
        check_flag("queue_full_after_drain", 1'b0, queue_full);
        for (int i = 0; i < n_rows; i++) begin
            if (rows[i].flushed && !seen[rows[i].rob]) begin
                $display("%s: flushed, no result", row_name[i]);
            end
        end
        $display("summary: %0d checks, %0d errors, %0d of %0d results", checks, errors,
                 seen_cnt, total_exp);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // scoreboard keyed by rob tag, sampled mid-cycle.
    initial begin
        int idx;
        forever begin
            @(negedge clk);
            if (arst_n) begin
                for (int l = 0; l < bank_num; l++) begin
                    if (result_en[l]) begin
                        idx = row_of_rob[result[l].rob];
                        if (idx < 0 || rows[idx].flushed || seen[result[l].rob]) begin
                            errors++;
                            $display("unexpected result on lane %0d for rob %0d rd %0d",
                                     l, result[l].rob, result[l].rd);
                        end else begin
                            seen[result[l].rob] = 1'b1;
                            seen_cnt++;
                            check_result(row_name[idx], rows[idx].exp, result[l]);
                        end
                    end
                end
            end
        end
    end

    initial begin
        wait (table_ready);
        repeat (n_rows * 40 + 100) @(posedge clk);
        $display("watchdog expired with %0d of %0d results still missing",
                 total_exp - seen_cnt, total_exp);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
iq_pkg.sv
uop_decoder.sv
issue_bank.sv
int_issue_queue.sv
preg_file.sv
int_alu.sv
writeback_stage.sv
int_backend_top.sv
tb_int_backend.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_int_backend
BUILD     ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for failure"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "variables: VERILATOR TOP BUILD LOG FILELIST VFLAGS"

$(BUILD)/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD) --top-module $(TOP) -f $(FILELIST)

test: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD) $(LOG)
